// File: dv/instrDecoderTb.sv
`timescale 1ns/1ps

`include "ft64_defs.svh"

module instrDecoderTb;
    import ft64IsaPkg::*;
    import ft64DecodePkg::*;

    localparam int NumInstr   = 600;
    // Worst case about six cycles per instruction plus drain
    localparam int CycleLimit = NumInstr * 6 + 400;

    typedef struct packed {
        instrT   instr;
        tagT     tag;
        logic    isAlu, isAlu0, isFpu, isFlowCtrl, isBranch, btUpdate;
        logic    rfw, canExcept;
        logic    isLoad, isStore, isMem, isRmw;
        memSizeT memSize;
        lenT     len;
        logic    hasConst;
        constT   constVal;
    } resultT;

    logic    clk, arstN, inValid, inReady, outReady, outValid;
    instrT   inInstr;
    tagT     inTag, outTag;
    regT     inRt;
    logic    isAlu, isAlu0, isFpu, isFlowCtrl, isBranch, btUpdate, rfw, canExcept;
    logic    isLoad, isStore, isMem, isRmw, hasConst;
    memSizeT memSize;
    lenT     len;
    constT   constVal;

    resultT  expQ[$];
    int      checked = 0;
    int      valueErrors = 0;
    int      flowErrors = 0;
    logic    firstActive = 1'b1;

    instrDecoder u_instrDecoder (
        .clk(clk), .arstN_i(arstN),
        .valid_i(inValid), .instr_i(inInstr), .tag_i(inTag), .rt_i(inRt), .ready_o(inReady),
        .ready_i(outReady), .valid_o(outValid), .tag_o(outTag),
        .isAlu_o(isAlu), .isAlu0_o(isAlu0), .isFpu_o(isFpu), .isFlowCtrl_o(isFlowCtrl),
        .isBranch_o(isBranch), .btUpdate_o(btUpdate), .rfw_o(rfw), .canExcept_o(canExcept),
        .isLoad_o(isLoad), .isStore_o(isStore), .isMem_o(isMem), .isRmw_o(isRmw),
        .memSize_o(memSize), .len_o(len), .hasConst_o(hasConst), .const_o(constVal)
    );

    // ====================
    // Reference model
    // ====================
    function automatic memSizeT sizeFromPattern(input logic [2:0] p);
        memSizeT s;
        if (p == 3'b100)
            s = `MEM_OCTA;
        else if (p[1:0] == 2'b10)
            s = `MEM_TETRA;
        else if (p[0])
            s = `MEM_WYDE;
        else
            s = `MEM_OCTA;
        return s;
    endfunction

    function automatic resultT modelDecode(input instrT ins, input regT rt, input tagT tg);
        resultT      r;
        opcodeT      op;
        functT       fn;
        logic [2:0]  sh;
        logic [29:0] field;
        logic        isR2, rti, selfLoop;
        r = '0;
        op = ins[5:0];
        fn = ins[31:26];
        sh = ins[25:23];
        isR2 = (op == `OP_R2);
        rti = isR2 && (fn == `FN_RTI);
        // Upper ten bits all ones, lowest bit follows the form bit
        selfLoop = (ins[31:22] == 10'h3FF) && (ins[21] == ins[7]);
        r.instr = ins;
        r.tag = tg;
        // Memory behaviour
        r.isLoad = (op == `OP_LB) || (op == `OP_LX);
        r.isStore = (op == `OP_SB) || (op == `OP_SX) || (op == `OP_CAS) || (op == `OP_AMO);
        r.isMem = r.isLoad || r.isStore;
        r.isRmw = (op == `OP_CAS) || (op == `OP_AMO);
        if (op == `OP_LB || op == `OP_SB)
            r.memSize = `MEM_BYTE;
        else if (op == `OP_LX)
            r.memSize = sizeFromPattern(ins[20:18]);
        else if (op == `OP_SX)
            r.memSize = sizeFromPattern(ins[15:13]);
        else if (op == `OP_AMO)
            r.memSize = (ins[23:21] < 3'd4) ? {1'b0, ins[22:21]} : `MEM_OCTA;
        else
            r.memSize = `MEM_OCTA;
        // Execution units
        r.isFlowCtrl = (op == `OP_BRK) || (op == `OP_BCC) || (op == `OP_JAL)
                       || (op == `OP_RET) || rti;
        r.isFpu = (op == `OP_FLOAT);
        r.isAlu = !(r.isFlowCtrl || r.isFpu);
        r.isAlu0 = (isR2 && (fn == `FN_MUL || fn == `FN_DIV))
                   || (isR2 && fn == `FN_SHIFTR && sh != `SHIFT_SHL && sh != `SHIFT_ASL)
                   || (op == `OP_MULI) || (op == `OP_DIVI);
        r.isBranch = (op == `OP_BCC);
        r.btUpdate = (op == `OP_JAL) || (op == `OP_RET) || (op == `OP_BRK) || rti;
        r.rfw = (rt != 5'd0) && ((isR2 && !rti) || op == `OP_ADDI || op == `OP_ANDI
                || op == `OP_MULI || op == `OP_DIVI || op == `OP_JAL || op == `OP_RET
                || op == `OP_LB || op == `OP_LX || op == `OP_CAS || op == `OP_AMO);
        r.canExcept = (op == `OP_MULI) || (op == `OP_DIVI) || r.isMem
                      || (isR2 && (fn == `FN_MUL || fn == `FN_DIV || rti))
                      || ((op == `OP_BCC) && selfLoop);
        // Length and constant
        r.len = ins[7] ? 3'd2 : (ins[6] ? 3'd6 : 3'd4);
        r.hasConst = (op == `OP_ADDI) || (op == `OP_ANDI) || (op == `OP_MULI)
                     || (op == `OP_DIVI) || (op == `OP_LB) || (op == `OP_LX)
                     || (op == `OP_SB) || (op == `OP_SX) || (op == `OP_CAS)
                     || (op == `OP_JAL) || (op == `OP_RET);
        if (ins[6])
            field = r.isStore ? {ins[47:23], ins[17:13]} : ins[47:18];
        else
            field = r.isStore ? {16'd0, ins[31:23], ins[17:13]} : {16'd0, ins[31:18]};
        if (ins[6])
            r.constVal = $signed({field, 34'd0}) >>> 34;
        else
            r.constVal = $signed({field[13:0], 50'd0}) >>> 50;
        return r;
    endfunction

    // ====================
    // Stimulus helpers
    // ====================
    function automatic instrT randomInstr();
        instrT       ins;
        logic [31:0] hi;
        logic [31:0] lo;
        opcodeT      op;
        hi = $urandom;
        lo = $urandom;
        ins = {hi[15:0], lo};
        case ($urandom_range(15))
            0:       op = `OP_R2;
            1:       op = `OP_BRK;
            2:       op = `OP_BCC;
            3:       op = `OP_JAL;
            4:       op = `OP_RET;
            5:       op = `OP_FLOAT;
            6:       op = `OP_ADDI;
            7:       op = `OP_ANDI;
            8:       op = `OP_MULI;
            9:       op = `OP_DIVI;
            10:      op = `OP_LB;
            11:      op = `OP_LX;
            12:      op = `OP_SB;
            13:      op = `OP_SX;
            14:      op = `OP_CAS;
            default: op = `OP_AMO;
        endcase
        ins[5:0] = op;
        // Mostly known R2 functions with an odd random one
        if (op == `OP_R2 && $urandom_range(7) != 0) begin
            case ($urandom_range(5))
                0: ins[31:26] = `FN_ADD;
                1: ins[31:26] = `FN_SUB;
                2: ins[31:26] = `FN_MUL;
                3: ins[31:26] = `FN_DIV;
                4: ins[31:26] = `FN_SHIFTR;
                default: ins[31:26] = `FN_RTI;
            endcase
        end
        if (op == `OP_BCC && $urandom_range(7) == 0)
            ins[31:21] = ins[7] ? 11'h7FF : 11'h7FE;
        return ins;
    endfunction

    function automatic regT randomReg();
        logic [31:0] v;
        v = $urandom;
        if ($urandom_range(7) == 0)
            v = 32'd0;
        return v[4:0];
    endfunction

    task automatic reportValue(input string what, input instrT ins,
                               input logic [63:0] gotV, input logic [63:0] expV);
        valueErrors++;
        $display("error %0t: %s got %h expected %h for instr %h", $time, what, gotV, expV, ins);
    endtask

    task automatic checkResult(input resultT e);
        assert (outTag == e.tag)
            else reportValue("tag", e.instr, 64'(outTag), 64'(e.tag));
        assert ({isAlu, isAlu0, isFpu, isFlowCtrl, isBranch, btUpdate}
                == {e.isAlu, e.isAlu0, e.isFpu, e.isFlowCtrl, e.isBranch, e.btUpdate})
            else reportValue("unit flags", e.instr,
                             64'({isAlu, isAlu0, isFpu, isFlowCtrl, isBranch, btUpdate}),
                             64'({e.isAlu, e.isAlu0, e.isFpu, e.isFlowCtrl, e.isBranch,
                                  e.btUpdate}));
        assert ({isLoad, isStore, isMem, isRmw, memSize}
                == {e.isLoad, e.isStore, e.isMem, e.isRmw, e.memSize})
            else reportValue("mem flags and size", e.instr,
                             64'({isLoad, isStore, isMem, isRmw, memSize}),
                             64'({e.isLoad, e.isStore, e.isMem, e.isRmw, e.memSize}));
        assert ({rfw, canExcept} == {e.rfw, e.canExcept})
            else reportValue("rfw and canExcept", e.instr,
                             64'({rfw, canExcept}), 64'({e.rfw, e.canExcept}));
        assert ({len, hasConst} == {e.len, e.hasConst})
            else reportValue("len and hasConst", e.instr,
                             64'({len, hasConst}), 64'({e.len, e.hasConst}));
        assert (constVal == e.constVal)
            else reportValue("constant", e.instr, constVal, e.constVal);
    endtask

    // ====================
    // Clock, monitor, timeout
    // ====================
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Sampled at the edge before the DUT registers update
    always @(posedge clk) begin
        if (!arstN || firstActive) begin
            assert (!outValid) else reportValue("valid_o around reset", '0, 64'(outValid), 0);
            if (arstN)
                firstActive <= 1'b0;
        end
        if (arstN) begin
            if (inValid && inReady)
                expQ.push_back(modelDecode(inInstr, inRt, inTag));
            if (outValid && outReady) begin
                assert (expQ.size() != 0) else begin
                    flowErrors++;
                    $display("Output transfer at %0t with no instruction outstanding", $time);
                end
                if (expQ.size() != 0) begin
                    checkResult(expQ.pop_front());
                    checked++;
                end
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles with %0d of %0d results checked",
                 CycleLimit, checked, NumInstr);
        $display("Some tests failed");
        $finish;
    end

    // ====================
    // Stimulus
    // ====================
    initial begin
        int  sent;
        tagT nextTag;
        sent = 0;
        nextTag = '0;
        void'($urandom(32'hbe10));
        arstN = 1'b1;
        inValid = 1'b0;
        inInstr = '0;
        inTag = '0;
        inRt = '0;
        outReady = 1'b0;
        #1 arstN = 1'b0;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        while (sent < NumInstr) begin
            @(posedge clk);
            if (inValid && inReady)
                sent++;
            outReady <= ($urandom_range(9) < 7);
            // New item only once the pending one is taken
            if (!inValid || inReady) begin
                if (sent < NumInstr && $urandom_range(9) < 8) begin
                    inValid <= 1'b1;
                    inInstr <= randomInstr();
                    inRt <= randomReg();
                    inTag <= nextTag;
                    nextTag++;
                end else begin
                    inValid <= 1'b0;
                end
            end
        end
        while (checked < NumInstr)
            @(posedge clk);
        // Give a stray extra output time to show up
        repeat (4) @(posedge clk);
        $display("Checked %0d results: %0d value errors, %0d flow errors",
                 checked, valueErrors, flowErrors);
        if (valueErrors == 0 && flowErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: rtl/constExtractor.sv
`timescale 1ns/1ps

`include "ft64_defs.svh"

module constExtractor (
    input  ft64IsaPkg::instrT       instr_i,
    input  logic                    isStore_i,
    output ft64DecodePkg::lenT      len_o,
    output logic                    hasConst_o,
    output ft64DecodePkg::constT    const_o
);
    import ft64IsaPkg::*;
    import ft64DecodePkg::*;

    opcodeT opcode;
    constT  shortConst;
    constT  longConst;

    assign opcode = instr_i[`OPCODE_MSB:`OPCODE_LSB];

    always_comb begin
        case (instr_i[`LEN_MSB:`LEN_LSB])
            2'b00:   len_o = `ILEN_STD;
            2'b01:   len_o = `ILEN_LONG;
            default: len_o = `ILEN_SHORT;
        endcase
    end

    always_comb begin
        case (opcode)
            `OP_ADDI, `OP_ANDI, `OP_MULI, `OP_DIVI,
            `OP_LB, `OP_LX, `OP_SB, `OP_SX, `OP_CAS,
            `OP_JAL, `OP_RET: hasConst_o = 1'b1;
            default:          hasConst_o = 1'b0;
        endcase
    end

    // Stores split the immediate around the source register field
    always_comb begin
        if (isStore_i) begin
            shortConst = {{50{instr_i[31]}}, instr_i[31:23], instr_i[17:13]};
            longConst  = {{34{instr_i[47]}}, instr_i[47:23], instr_i[17:13]};
        end else begin
            shortConst = {{50{instr_i[31]}}, instr_i[31:18]};
            longConst  = {{34{instr_i[47]}}, instr_i[47:18]};
        end
    end

    // Bit 6 selects the 48-bit form
    assign const_o = instr_i[`LEN_LSB] ? longConst : shortConst;

endmodule

// File: rtl/ft64DecodePkg.sv
package ft64DecodePkg;

    // Sign-extended immediate
    typedef logic [63:0] constT;

    // Instruction length in bytes
    typedef logic [2:0]  lenT;

    // Memory access size code
    typedef logic [2:0]  memSizeT;

endpackage : ft64DecodePkg

// File: rtl/ft64IsaPkg.sv
package ft64IsaPkg;

    // Full instruction word with shorter forms in the low bits
    typedef logic [47:0] instrT;

    // Major opcode and R2 function fields
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // Architectural or renamed register number
    typedef logic [4:0]  regT;

    // Instruction queue id
    typedef logic [4:0]  tagT;

endpackage : ft64IsaPkg

// File: rtl/ft64_defs.svh
`ifndef FT64_DEFS_SVH
`define FT64_DEFS_SVH

// ====================
// Instruction fields
// ====================
`define OPCODE_LSB      0
`define OPCODE_MSB      5
`define LEN_LSB         6
`define LEN_MSB         7
`define FUNCT_LSB       26
`define FUNCT_MSB       31

// Shift op inside an R2 shift
`define SHOP_LSB        23
`define SHOP_MSB        25

// Branch displacement
`define BRDISP_LSB      21
`define BRDISP_MSB      31

// Size selectors for LX, SX and AMO
`define LXSZ_LSB        18
`define LXSZ_MSB        20
`define SXSZ_LSB        13
`define SXSZ_MSB        15
`define AMOSZ_LSB       21
`define AMOSZ_MSB       23

// ====================
// Opcodes
// ====================
`define OP_BRK          6'h00
`define OP_R2           6'h02
`define OP_ADDI         6'h04
`define OP_MULI         6'h06
`define OP_ANDI         6'h08
`define OP_FLOAT        6'h0F
`define OP_LB           6'h13
`define OP_SB           6'h15
`define OP_JAL          6'h18
`define OP_LX           6'h20
`define OP_SX           6'h24
`define OP_CAS          6'h26
`define OP_RET          6'h29
`define OP_AMO          6'h2E
`define OP_BCC          6'h30
`define OP_DIVI         6'h3E

// R2 function codes
`define FN_ADD          6'h04
`define FN_SUB          6'h05
`define FN_SHIFTR       6'h2F
`define FN_RTI          6'h32
`define FN_MUL          6'h3A
`define FN_DIV          6'h3E

// Left shifts stay on any ALU
`define SHIFT_SHL       3'd0
`define SHIFT_ASL       3'd1

// ====================
// Sizes and lengths
// ====================
`define MEM_BYTE        3'd0
`define MEM_WYDE        3'd1
`define MEM_TETRA       3'd2
`define MEM_OCTA        3'd3

`define ILEN_SHORT      3'd2
`define ILEN_STD        3'd4
`define ILEN_LONG       3'd6

`endif

// File: rtl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic                     clk,
    input  logic                     arstN_i,
    // Instruction in
    input  logic                     valid_i,
    input  ft64IsaPkg::instrT        instr_i,
    input  ft64IsaPkg::tagT          tag_i,
    input  ft64IsaPkg::regT          rt_i,
    output logic                     ready_o,
    // Decode out
    input  logic                     ready_i,
    output logic                     valid_o,
    output ft64IsaPkg::tagT          tag_o,
    output logic                     isAlu_o,
    output logic                     isAlu0_o,
    output logic                     isFpu_o,
    output logic                     isFlowCtrl_o,
    output logic                     isBranch_o,
    output logic                     btUpdate_o,
    output logic                     rfw_o,
    output logic                     canExcept_o,
    output logic                     isLoad_o,
    output logic                     isStore_o,
    output logic                     isMem_o,
    output logic                     isRmw_o,
    output ft64DecodePkg::memSizeT   memSize_o,
    output ft64DecodePkg::lenT       len_o,
    output logic                     hasConst_o,
    output ft64DecodePkg::constT     const_o
);
    import ft64IsaPkg::*;
    import ft64DecodePkg::*;

    logic    isAlu, isAlu0, isFpu, isFlowCtrl, isBranch, btUpdate, rfw, canExcept;
    logic    isLoad, isStore, isMem, isRmw, hasConst;
    memSizeT memSize;
    lenT     len;
    constT   constVal;
    logic    accept;

    // ====================
    // Combinational decode
    // ====================
    memClassifier u_memClassifier (
        .instr_i   (instr_i),
        .isLoad_o  (isLoad),
        .isStore_o (isStore),
        .isMem_o   (isMem),
        .isRmw_o   (isRmw),
        .memSize_o (memSize)
    );

    unitClassifier u_unitClassifier (
        .instr_i      (instr_i),
        .rt_i         (rt_i),
        .isMem_i      (isMem),
        .isAlu_o      (isAlu),
        .isAlu0_o     (isAlu0),
        .isFpu_o      (isFpu),
        .isFlowCtrl_o (isFlowCtrl),
        .isBranch_o   (isBranch),
        .btUpdate_o   (btUpdate),
        .rfw_o        (rfw),
        .canExcept_o  (canExcept)
    );

    constExtractor u_constExtractor (
        .instr_i    (instr_i),
        .isStore_i  (isStore),
        .len_o      (len),
        .hasConst_o (hasConst),
        .const_o    (constVal)
    );

    // ====================
    // Output register
    // ====================
    // Slot frees up when empty or being drained this cycle
    assign ready_o = !valid_o || ready_i;
    assign accept  = valid_i && ready_o;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_o        <= tag_i;
            isAlu_o      <= isAlu;
            isAlu0_o     <= isAlu0;
            isFpu_o      <= isFpu;
            isFlowCtrl_o <= isFlowCtrl;
            isBranch_o   <= isBranch;
            btUpdate_o   <= btUpdate;
            rfw_o        <= rfw;
            canExcept_o  <= canExcept;
            isLoad_o     <= isLoad;
            isStore_o    <= isStore;
            isMem_o      <= isMem;
            isRmw_o      <= isRmw;
            memSize_o    <= memSize;
            len_o        <= len;
            hasConst_o   <= hasConst;
            const_o      <= constVal;
        end
    end

endmodule

// File: rtl/memClassifier.sv
`timescale 1ns/1ps

`include "ft64_defs.svh"

module memClassifier (
    input  ft64IsaPkg::instrT        instr_i,
    output logic                     isLoad_o,
    output logic                     isStore_o,
    output logic                     isMem_o,
    output logic                     isRmw_o,
    output ft64DecodePkg::memSizeT   memSize_o
);
    import ft64IsaPkg::*;
    import ft64DecodePkg::*;

    opcodeT  opcode;
    memSizeT lxSize;
    memSizeT sxSize;
    memSizeT amoSize;

    // Shared size encoding of LX and SX
    function automatic memSizeT decodeSizeField(input logic [2:0] field);
        memSizeT size;
        casez (field)
            3'b100:  size = `MEM_OCTA;
            3'b?10:  size = `MEM_TETRA;
            3'b??1:  size = `MEM_WYDE;
            default: size = `MEM_OCTA;
        endcase
        return size;
    endfunction

    assign opcode = instr_i[`OPCODE_MSB:`OPCODE_LSB];
    assign lxSize = decodeSizeField(instr_i[`LXSZ_MSB:`LXSZ_LSB]);
    assign sxSize = decodeSizeField(instr_i[`SXSZ_MSB:`SXSZ_LSB]);

    // AMO carries a plain size code
    always_comb begin
        case (instr_i[`AMOSZ_MSB:`AMOSZ_LSB])
            3'd0:    amoSize = `MEM_BYTE;
            3'd1:    amoSize = `MEM_WYDE;
            3'd2:    amoSize = `MEM_TETRA;
            default: amoSize = `MEM_OCTA;
        endcase
    end

    always_comb begin
        isLoad_o  = 1'b0;
        isStore_o = 1'b0;
        isRmw_o   = 1'b0;
        memSize_o = `MEM_OCTA;
        case (opcode)
            `OP_LB: begin
                isLoad_o  = 1'b1;
                memSize_o = `MEM_BYTE;
            end
            `OP_LX: begin
                isLoad_o  = 1'b1;
                memSize_o = lxSize;
            end
            `OP_SB: begin
                isStore_o = 1'b1;
                memSize_o = `MEM_BYTE;
            end
            `OP_SX: begin
                isStore_o = 1'b1;
                memSize_o = sxSize;
            end
            // Atomics count as stores for issue
            `OP_CAS: begin
                isStore_o = 1'b1;
                isRmw_o   = 1'b1;
            end
            `OP_AMO: begin
                isStore_o = 1'b1;
                isRmw_o   = 1'b1;
                memSize_o = amoSize;
            end
            default: memSize_o = `MEM_OCTA;
        endcase
    end

    assign isMem_o = isLoad_o | isStore_o;

endmodule

// File: rtl/unitClassifier.sv
`timescale 1ns/1ps

`include "ft64_defs.svh"

module unitClassifier (
    input  ft64IsaPkg::instrT   instr_i,
    input  ft64IsaPkg::regT     rt_i,
    input  logic                isMem_i,
    output logic                isAlu_o,
    output logic                isAlu0_o,
    output logic                isFpu_o,
    output logic                isFlowCtrl_o,
    output logic                isBranch_o,
    output logic                btUpdate_o,
    output logic                rfw_o,
    output logic                canExcept_o
);
    import ft64IsaPkg::*;

    opcodeT      opcode;
    functT       funct;
    logic [2:0]  shiftOp;
    logic [10:0] brDisp;
    logic        brToSelf;
    logic        writesReg;

    assign opcode  = instr_i[`OPCODE_MSB:`OPCODE_LSB];
    assign funct   = instr_i[`FUNCT_MSB:`FUNCT_LSB];
    assign shiftOp = instr_i[`SHOP_MSB:`SHOP_LSB];
    assign brDisp  = instr_i[`BRDISP_MSB:`BRDISP_LSB];

    // Self-loop offset depends on the instruction form
    assign brToSelf = instr_i[7] ? (brDisp == 11'h7FF) : (brDisp == 11'h7FE);

    always_comb begin
        isAlu_o      = 1'b1;
        isAlu0_o     = 1'b0;
        isFpu_o      = 1'b0;
        isFlowCtrl_o = 1'b0;
        isBranch_o   = 1'b0;
        btUpdate_o   = 1'b0;
        writesReg    = 1'b0;
        // Any memory op may fault
        canExcept_o  = isMem_i;
        case (opcode)
            `OP_R2: begin
                writesReg = 1'b1;
                case (funct)
                    `FN_RTI: begin
                        isAlu_o      = 1'b0;
                        isFlowCtrl_o = 1'b1;
                        btUpdate_o   = 1'b1;
                        canExcept_o  = 1'b1;
                        writesReg    = 1'b0;
                    end
                    `FN_MUL, `FN_DIV: begin
                        isAlu0_o    = 1'b1;
                        canExcept_o = 1'b1;
                    end
                    `FN_SHIFTR: isAlu0_o = (shiftOp != `SHIFT_SHL) && (shiftOp != `SHIFT_ASL);
                    default:    isAlu0_o = 1'b0;
                endcase
            end
            `OP_BRK: begin
                isAlu_o      = 1'b0;
                isFlowCtrl_o = 1'b1;
                btUpdate_o   = 1'b1;
            end
            `OP_BCC: begin
                isAlu_o      = 1'b0;
                isFlowCtrl_o = 1'b1;
                isBranch_o   = 1'b1;
                canExcept_o  = isMem_i | brToSelf;
            end
            // Calculated targets refresh the branch target buffer
            `OP_JAL, `OP_RET: begin
                isAlu_o      = 1'b0;
                isFlowCtrl_o = 1'b1;
                btUpdate_o   = 1'b1;
                writesReg    = 1'b1;
            end
            `OP_FLOAT: begin
                isAlu_o = 1'b0;
                isFpu_o = 1'b1;
            end
            `OP_MULI, `OP_DIVI: begin
                isAlu0_o    = 1'b1;
                canExcept_o = 1'b1;
                writesReg   = 1'b1;
            end
            `OP_ADDI, `OP_ANDI, `OP_LB, `OP_LX, `OP_CAS, `OP_AMO: writesReg = 1'b1;
            default: writesReg = 1'b0;
        endcase
    end

    // r0 is never written
    assign rfw_o = writesReg && (rt_i != '0);

endmodule

// File: run.sh
#!/bin/sh
# Build the decoder testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
    --top-module instrDecoderTb -o instrDecoderTb \
    && ./obj_dir/instrDecoderTb | tee sim.log
grep -qs "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim.f
+incdir+rtl
rtl/ft64IsaPkg.sv
rtl/ft64DecodePkg.sv
rtl/memClassifier.sv
rtl/unitClassifier.sv
rtl/constExtractor.sv
rtl/instrDecoder.sv
dv/instrDecoderTb.sv
